/* rtl/mem_ui_pkg.sv */
package mem_ui_pkg;

  localparam int COL_WIDTH  = 4;
  localparam int ROW_WIDTH  = 3;
  localparam int BANK_WIDTH = 2;
  localparam int RANK_WIDTH = 1;
  localparam int ADDR_WIDTH = RANK_WIDTH + BANK_WIDTH + ROW_WIDTH + COL_WIDTH;
  localparam int DATA_WIDTH = 16;

  typedef logic [ADDR_WIDTH-1:0] mem_addr_t;  // rank, bank, row, col from the top down.
  typedef logic [COL_WIDTH-1:0]  col_t;
  typedef logic [ROW_WIDTH-1:0]  row_t;
  typedef logic [BANK_WIDTH-1:0] bank_t;
  typedef logic [RANK_WIDTH-1:0] rank_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [3:0]            buf_addr_t;  // sixteen buffer slots.
  typedef logic [2:0]            cmd_t;

  localparam cmd_t CMD_WRITE = 3'b000;
  localparam cmd_t CMD_READ  = 3'b001;

endpackage

/* rtl/ui_cmd.sv */
`timescale 1ns/1ps

module ui_cmd import mem_ui_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      accept_ns,
  input  logic      rd_buf_full,
  input  logic      wr_req_16,
  input  mem_addr_t app_addr,
  input  cmd_t      app_cmd,
  input  logic      app_hi_pri,
  input  logic      app_en,
  input  buf_addr_t wr_data_buf_addr,
  input  buf_addr_t rd_data_buf_addr_r,
  output logic      app_rdy,
  output logic      use_addr,
  output rank_t     rank,
  output bank_t     bank,
  output row_t      row,
  output col_t      col,
  output cmd_t      cmd,
  output logic      hi_priority,
  output logic      rd_accepted,
  output logic      wr_accepted,
  output buf_addr_t data_buf_addr
);

  logic      app_rdy_r;
  logic      app_en_r1;
  logic      app_en_r2;
  mem_addr_t app_addr_r1;
  mem_addr_t app_addr_r2;
  cmd_t      app_cmd_r1;
  cmd_t      app_cmd_r2;
  logic      app_hi_pri_r1;
  logic      app_hi_pri_r2;
  mem_addr_t addr_sel;
  logic      rd;
  logic      wr;

  always_ff @(posedge clk) begin
    if (reset) begin
      app_rdy_r <= 1'b0;
      app_en_r1 <= 1'b0;
      app_en_r2 <= 1'b0;
    end else begin
      app_rdy_r <= accept_ns && !rd_buf_full && !wr_req_16;
      if (app_rdy_r) begin
        app_en_r1 <= app_en;
        app_en_r2 <= app_en_r1;
      end
    end
  end

  // both stages freeze while not ready.
  always_ff @(posedge clk) begin
    if (app_rdy_r) begin
      app_addr_r1   <= app_addr;
      app_addr_r2   <= app_addr_r1;
      app_cmd_r1    <= app_cmd;
      app_cmd_r2    <= app_cmd_r1;
      app_hi_pri_r1 <= app_hi_pri;
      app_hi_pri_r2 <= app_hi_pri_r1;
    end
  end

  // fields run one cycle ahead of use_addr.
  assign addr_sel    = app_rdy_r ? app_addr_r1 : app_addr_r2;
  assign col         = addr_sel[COL_WIDTH-1:0];
  assign row         = addr_sel[COL_WIDTH +: ROW_WIDTH];
  assign bank        = addr_sel[COL_WIDTH+ROW_WIDTH +: BANK_WIDTH];
  assign rank        = addr_sel[ADDR_WIDTH-1 -: RANK_WIDTH];
  assign cmd         = app_rdy_r ? app_cmd_r1 : app_cmd_r2;
  assign hi_priority = app_rdy_r ? app_hi_pri_r1 : app_hi_pri_r2;

  assign app_rdy  = app_rdy_r;
  assign use_addr = app_en_r2 && app_rdy_r;

  assign rd          = (app_cmd_r2 == CMD_READ);
  assign wr          = (app_cmd_r2 == CMD_WRITE);
  assign rd_accepted = use_addr && rd;
  assign wr_accepted = use_addr && wr;

  assign data_buf_addr = wr ? wr_data_buf_addr : rd_data_buf_addr_r;

endmodule

/* rtl/rd_data_buf.sv */
`timescale 1ns/1ps

module rd_data_buf import mem_ui_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      rd_accepted,
  input  logic      rd_fill,
  input  buf_addr_t rd_fill_addr,
  input  data_t     rd_fill_data,
  output buf_addr_t rd_data_buf_addr_r,
  output logic      rd_buf_full,
  output logic      app_rd_data_valid,
  output data_t     app_rd_data
);

  localparam int SLOTS     = 2 ** $bits(buf_addr_t);
  localparam int PTR_WIDTH = $bits(buf_addr_t) + 1;
  localparam logic [PTR_WIDTH-1:0] FULL_LEVEL = PTR_WIDTH'(SLOTS - 1);

  logic [PTR_WIDTH-1:0] alloc_ptr;
  logic [PTR_WIDTH-1:0] ret_ptr;
  logic [PTR_WIDTH-1:0] used;
  logic [SLOTS-1:0]     filled;
  data_t                slot_data [SLOTS];
  buf_addr_t            head;
  logic                 head_ready;

  assign head               = ret_ptr[PTR_WIDTH-2:0];
  assign head_ready         = filled[head];
  assign used               = alloc_ptr - ret_ptr;
  assign rd_buf_full        = (used >= FULL_LEVEL);  // room for two in flight.
  assign rd_data_buf_addr_r = alloc_ptr[PTR_WIDTH-2:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      alloc_ptr         <= '0;
      ret_ptr           <= '0;
      filled            <= '0;
      app_rd_data_valid <= 1'b0;
    end else begin
      app_rd_data_valid <= head_ready;
      if (rd_accepted) alloc_ptr <= alloc_ptr + 1;
      if (head_ready) begin
        ret_ptr      <= ret_ptr + 1;
        filled[head] <= 1'b0;
      end
      if (rd_fill) filled[rd_fill_addr] <= 1'b1;  // never the slot being returned.
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fill) slot_data[rd_fill_addr] <= rd_fill_data;
    if (head_ready) app_rd_data <= slot_data[head];
  end

endmodule

/* rtl/wr_data_buf.sv */
`timescale 1ns/1ps

module wr_data_buf import mem_ui_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      app_wdf_wren,
  input  data_t     app_wdf_data,
  input  logic      wr_accepted,
  input  buf_addr_t wr_rd_addr,
  input  logic      wr_release,
  output logic      app_wdf_rdy,
  output buf_addr_t wr_data_buf_addr,
  output data_t     wr_rd_data,
  output logic      wr_req_16
);

  localparam int SLOTS     = 2 ** $bits(buf_addr_t);
  localparam int PTR_WIDTH = $bits(buf_addr_t) + 1;
  localparam logic [PTR_WIDTH-1:0] ALL_SLOTS  = PTR_WIDTH'(SLOTS);
  localparam logic [PTR_WIDTH-1:0] FULL_LEVEL = PTR_WIDTH'(SLOTS - 1);

  logic [PTR_WIDTH-1:0] fill_ptr;
  logic [PTR_WIDTH-1:0] bind_ptr;
  logic [PTR_WIDTH-1:0] rel_ptr;
  logic [PTR_WIDTH-1:0] occupancy;
  logic [PTR_WIDTH-1:0] bound;
  data_t                slot_data [SLOTS];

  assign occupancy        = fill_ptr - rel_ptr;
  assign bound            = bind_ptr - rel_ptr;  // slots owned by queued writes.
  assign app_wdf_rdy      = (occupancy != ALL_SLOTS);
  assign wr_req_16        = (bound >= FULL_LEVEL);
  assign wr_data_buf_addr = bind_ptr[PTR_WIDTH-2:0];
  assign wr_rd_data       = slot_data[wr_rd_addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_ptr <= '0;
      bind_ptr <= '0;
      rel_ptr  <= '0;
    end else begin
      if (app_wdf_wren && app_wdf_rdy) fill_ptr <= fill_ptr + 1;
      if (wr_accepted) bind_ptr <= bind_ptr + 1;
      if (wr_release) rel_ptr <= rel_ptr + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (app_wdf_wren && app_wdf_rdy) slot_data[fill_ptr[PTR_WIDTH-2:0]] <= app_wdf_data;
  end

endmodule

/* rtl/cmd_exec.sv */
`timescale 1ns/1ps

module cmd_exec import mem_ui_pkg::*; #(
  parameter int QUEUE_DEPTH = 8  // power of two.
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      use_addr,
  input  rank_t     rank,
  input  bank_t     bank,
  input  row_t      row,
  input  col_t      col,
  input  cmd_t      cmd,
  input  logic      hi_priority,
  input  buf_addr_t data_buf_addr,
  input  logic      exec_gnt,
  input  data_t     exec_rdata,
  input  data_t     wr_rd_data,
  output logic      accept_ns,
  output logic      exec_req,
  output logic      exec_hi,
  output logic      exec_we,
  output mem_addr_t exec_addr,
  output data_t     exec_wdata,
  output buf_addr_t wr_rd_addr,
  output logic      wr_release,
  output logic      rd_fill,
  output buf_addr_t rd_fill_addr,
  output data_t     rd_fill_data
);

  localparam int QW = $clog2(QUEUE_DEPTH);
  localparam int CW = $clog2(QUEUE_DEPTH + 1);
  localparam logic [CW-1:0] ACCEPT_LIMIT = CW'(QUEUE_DEPTH - 2);

  typedef enum logic [1:0] {IDLE, REQUEST, READ_WAIT} state_t;

  state_t        state;
  logic [QW-1:0] wr_ptr;
  logic [QW-1:0] rd_ptr;
  logic [CW-1:0] count;
  mem_addr_t     q_addr [QUEUE_DEPTH];
  cmd_t          q_cmd [QUEUE_DEPTH];
  logic          q_hi [QUEUE_DEPTH];
  buf_addr_t     q_buf [QUEUE_DEPTH];
  mem_addr_t     req_addr_r;
  cmd_t          req_cmd_r;
  logic          req_hi_r;
  cmd_t          head_cmd;
  logic          head_exec;
  logic          pop;

  assign accept_ns = (count <= ACCEPT_LIMIT);  // two free entries.
  assign head_cmd  = q_cmd[rd_ptr];
  assign head_exec = (head_cmd == CMD_WRITE) || (head_cmd == CMD_READ);
  assign pop = (state == IDLE && count != '0 && !head_exec) ||
               (state == REQUEST && exec_gnt && exec_we) ||
               (state == READ_WAIT);

  assign exec_req     = (state == REQUEST);
  assign exec_hi      = q_hi[rd_ptr];
  assign exec_we      = (head_cmd == CMD_WRITE);
  assign exec_addr    = q_addr[rd_ptr];
  assign exec_wdata   = wr_rd_data;
  assign wr_rd_addr   = q_buf[rd_ptr];
  assign rd_fill      = (state == READ_WAIT);  // rdata lands the cycle after grant.
  assign rd_fill_addr = q_buf[rd_ptr];
  assign rd_fill_data = exec_rdata;

  // fields are sampled a cycle early, so the registered copy matches use_addr.
  always_ff @(posedge clk) begin
    req_addr_r <= {rank, bank, row, col};
    req_cmd_r  <= cmd;
    req_hi_r   <= hi_priority;
    if (use_addr) begin
      q_addr[wr_ptr] <= req_addr_r;
      q_cmd[wr_ptr]  <= req_cmd_r;
      q_hi[wr_ptr]   <= req_hi_r;
      q_buf[wr_ptr]  <= data_buf_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      wr_release <= 1'b0;
    end else begin
      wr_release <= (state == REQUEST) && exec_gnt && exec_we;
      if (use_addr) wr_ptr <= wr_ptr + 1;
      if (pop) rd_ptr <= rd_ptr + 1;
      count <= count + CW'(use_addr) - CW'(pop);
      case (state)
        IDLE:      if (count != '0 && head_exec) state <= REQUEST;
        REQUEST:   if (exec_gnt) state <= exec_we ? IDLE : READ_WAIT;
        default:   state <= IDLE;
      endcase
    end
  end

endmodule

/* rtl/refresh_ctrl.sv */
`timescale 1ns/1ps

module refresh_ctrl #(
  parameter int REFRESH_INTERVAL = 64,
  parameter int REFRESH_CYCLES   = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic ref_gnt,
  output logic ref_req,
  output logic ref_urgent
);

  localparam int IW = $clog2(REFRESH_INTERVAL);
  localparam int BW = $clog2(REFRESH_CYCLES + 1);
  localparam logic [IW-1:0] INTERVAL_LAST = IW'(REFRESH_INTERVAL - 1);
  localparam logic [IW-1:0] URGENT_WAIT   = IW'(REFRESH_INTERVAL / 2);
  localparam logic [BW-1:0] BUSY_LOAD     = BW'(REFRESH_CYCLES);

  logic [IW-1:0] interval_cnt;
  logic [IW-1:0] wait_cnt;
  logic [BW-1:0] busy_cnt;

  assign ref_urgent = ref_req && (wait_cnt >= URGENT_WAIT);

  always_ff @(posedge clk) begin
    if (reset) begin
      interval_cnt <= '0;
      wait_cnt     <= '0;
      busy_cnt     <= '0;
      ref_req      <= 1'b0;
    end else begin
      interval_cnt <= (interval_cnt == INTERVAL_LAST) ? '0 : interval_cnt + 1;
      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1;
        if (busy_cnt == BW'(1)) ref_req <= 1'b0;  // refresh done.
      end else if (ref_gnt) begin
        busy_cnt <= BUSY_LOAD;
      end
      if (ref_req && busy_cnt == '0 && !ref_gnt) wait_cnt <= wait_cnt + 1;
      else wait_cnt <= '0;
      if (interval_cnt == INTERVAL_LAST) ref_req <= 1'b1;
    end
  end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import mem_ui_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      exec_req,
  input  logic      exec_hi,
  input  logic      exec_we,
  input  mem_addr_t exec_addr,
  input  data_t     exec_wdata,
  input  logic      ref_req,
  input  logic      ref_urgent,
  output logic      exec_gnt,
  output logic      ref_gnt,
  output data_t     exec_rdata
);

  logic  ref_owner;
  data_t mem [2**ADDR_WIDTH];

  initial begin
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      mem[i] = '0;  // unwritten words read as zero.
    end
  end

  always_comb begin
    exec_gnt = 1'b0;
    ref_gnt  = 1'b0;
    if (ref_owner && ref_req) begin
      ref_gnt = 1'b1;  // refresh keeps the port once started.
    end else if (ref_req && ref_urgent) begin
      ref_gnt = 1'b1;
    end else if (exec_req && (exec_hi || !ref_req)) begin
      exec_gnt = 1'b1;
    end else if (ref_req) begin
      ref_gnt = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) ref_owner <= 1'b0;
    else ref_owner <= ref_gnt;
  end

  always_ff @(posedge clk) begin
    if (exec_gnt && exec_we) mem[exec_addr] <= exec_wdata;
    if (exec_gnt && !exec_we) exec_rdata <= mem[exec_addr];
  end

endmodule

/* rtl/mem_ui_top.sv */
`timescale 1ns/1ps

module mem_ui_top import mem_ui_pkg::*; #(
  parameter int QUEUE_DEPTH      = 8,
  parameter int REFRESH_INTERVAL = 64,
  parameter int REFRESH_CYCLES   = 4
) (
  input  logic      clk,
  input  logic      reset,
  input  mem_addr_t app_addr,
  input  cmd_t      app_cmd,
  input  logic      app_hi_pri,
  input  logic      app_en,
  output logic      app_rdy,
  input  logic      app_wdf_wren,
  input  data_t     app_wdf_data,
  output logic      app_wdf_rdy,
  output logic      app_rd_data_valid,
  output data_t     app_rd_data
);

  logic      accept_ns;
  logic      rd_buf_full;
  logic      wr_req_16;
  logic      use_addr;
  rank_t     rank;
  bank_t     bank;
  row_t      row;
  col_t      col;
  cmd_t      cmd;
  logic      hi_priority;
  logic      rd_accepted;
  logic      wr_accepted;
  buf_addr_t data_buf_addr;
  buf_addr_t wr_data_buf_addr;
  buf_addr_t rd_data_buf_addr_r;
  buf_addr_t wr_rd_addr;
  data_t     wr_rd_data;
  logic      wr_release;
  logic      rd_fill;
  buf_addr_t rd_fill_addr;
  data_t     rd_fill_data;
  logic      exec_req;
  logic      exec_hi;
  logic      exec_we;
  mem_addr_t exec_addr;
  data_t     exec_wdata;
  logic      exec_gnt;
  data_t     exec_rdata;
  logic      ref_req;
  logic      ref_urgent;
  logic      ref_gnt;

  ui_cmd ui_cmd0 (
    .clk, .reset, .accept_ns, .rd_buf_full, .wr_req_16,
    .app_addr, .app_cmd, .app_hi_pri, .app_en,
    .wr_data_buf_addr, .rd_data_buf_addr_r,
    .app_rdy, .use_addr, .rank, .bank, .row, .col, .cmd, .hi_priority,
    .rd_accepted, .wr_accepted, .data_buf_addr
  );

  rd_data_buf rd_data_buf0 (
    .clk, .reset, .rd_accepted, .rd_fill, .rd_fill_addr, .rd_fill_data,
    .rd_data_buf_addr_r, .rd_buf_full, .app_rd_data_valid, .app_rd_data
  );

  wr_data_buf wr_data_buf0 (
    .clk, .reset, .app_wdf_wren, .app_wdf_data, .wr_accepted, .wr_rd_addr, .wr_release,
    .app_wdf_rdy, .wr_data_buf_addr, .wr_rd_data, .wr_req_16
  );

  cmd_exec #(.QUEUE_DEPTH(QUEUE_DEPTH)) cmd_exec0 (
    .clk, .reset, .use_addr, .rank, .bank, .row, .col, .cmd, .hi_priority,
    .data_buf_addr, .exec_gnt, .exec_rdata, .wr_rd_data,
    .accept_ns, .exec_req, .exec_hi, .exec_we, .exec_addr, .exec_wdata,
    .wr_rd_addr, .wr_release, .rd_fill, .rd_fill_addr, .rd_fill_data
  );

  refresh_ctrl #(
    .REFRESH_INTERVAL(REFRESH_INTERVAL),
    .REFRESH_CYCLES(REFRESH_CYCLES)
  ) refresh_ctrl0 (
    .clk, .reset, .ref_gnt, .ref_req, .ref_urgent
  );

  mem_arbiter mem_arbiter0 (
    .clk, .reset, .exec_req, .exec_hi, .exec_we, .exec_addr, .exec_wdata,
    .ref_req, .ref_urgent, .exec_gnt, .ref_gnt, .exec_rdata
  );

endmodule

/* testbench/tb_mem_ui.sv */
`timescale 1ns/1ps

module tb_mem_ui import mem_ui_pkg::*; ();

  localparam int          RESET_CYCLES  = 5;
  localparam int          DRIVE_DELAY   = 1;
  localparam int unsigned SEED          = 32'h5d169cf4;
  localparam int          NUM_RANDOM    = 200;
  localparam int          NUM_BURST     = 64;
  localparam int          NUM_HI        = 64;
  localparam int          TOTAL_CMDS    = NUM_RANDOM + NUM_BURST + NUM_HI;
  localparam int          CYCLES_PER_CMD = 24;  // queue stall, refresh and idle gap together.
  localparam int          TIMEOUT_CYCLES = TOTAL_CMDS * CYCLES_PER_CMD + 500;

  logic      clk;
  logic      reset;
  mem_addr_t app_addr;
  cmd_t      app_cmd;
  logic      app_hi_pri;
  logic      app_en;
  logic      app_rdy;
  logic      app_wdf_wren;
  data_t     app_wdf_data;
  logic      app_wdf_rdy;
  logic      app_rd_data_valid;
  data_t     app_rd_data;

  data_t     model [2**ADDR_WIDTH];
  data_t     exp_data_q [$];
  mem_addr_t exp_addr_q [$];
  string     exp_name_q [$];
  int        issued_count;
  int        use_count;
  int        cycle_count;

  mem_ui_top #(
    .QUEUE_DEPTH(8),
    .REFRESH_INTERVAL(32),  // short interval, so refresh hits many commands.
    .REFRESH_CYCLES(4)
  ) dut0 (
    .clk(clk),
    .reset(reset),
    .app_addr(app_addr),
    .app_cmd(app_cmd),
    .app_hi_pri(app_hi_pri),
    .app_en(app_en),
    .app_rdy(app_rdy),
    .app_wdf_wren(app_wdf_wren),
    .app_wdf_data(app_wdf_data),
    .app_wdf_rdy(app_wdf_rdy),
    .app_rd_data_valid(app_rd_data_valid),
    .app_rd_data(app_rd_data)
  );

  always #50 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_data(input string test, input mem_addr_t addr,
                              input data_t expected, input data_t actual);
    if (actual !== expected)
      stop_on_error($sformatf("[FAIL] %s: read of 0x%03h expected 0x%04h actual 0x%04h",
                              test, addr, expected, actual));
  endtask

  task automatic compare_bit(input string test, input logic expected, input logic actual);
    if (actual !== expected)
      stop_on_error($sformatf("[FAIL] %s: expected %b actual %b", test, expected, actual));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  // model update in acceptance order.
  task automatic record_accept(input string test, input cmd_t c, input mem_addr_t a,
                               input data_t d);
    issued_count++;
    if (c == CMD_WRITE) begin
      model[a] = d;
    end else if (c == CMD_READ) begin
      exp_data_q.push_back(model[a]);
      exp_addr_q.push_back(a);
      exp_name_q.push_back(test);
    end
  endtask

  // called at the drive point; returns at the drive point after acceptance.
  task automatic issue_cmd(input string test, input cmd_t c, input mem_addr_t a,
                           input logic hi, input data_t d);
    logic data_pending;
    logic word_taken;
    logic cmd_taken;
    data_pending = (c == CMD_WRITE);
    cmd_taken    = 1'b0;
    app_cmd      = c;
    app_addr     = a;
    app_hi_pri   = hi;
    app_wdf_data = d;
    while (!cmd_taken) begin
      app_wdf_wren = data_pending;
      app_en       = !data_pending || app_wdf_rdy;  // never ahead of its word.
      word_taken   = data_pending && app_wdf_rdy;
      cmd_taken    = app_en && app_rdy;
      @(posedge clk);
      #DRIVE_DELAY;
      if (word_taken) data_pending = 1'b0;
    end
    app_en       = 1'b0;
    app_wdf_wren = 1'b0;
    record_accept(test, c, a, d);
  endtask

  task automatic random_cmd(input string test, input logic force_hi);
    int unsigned pick;
    cmd_t        c;
    mem_addr_t   a;
    logic        hi;
    pick = $urandom % 16;
    if (pick == 0) c = cmd_t'(2 + $urandom % 6);  // retired without access.
    else if (pick < 8) c = CMD_WRITE;
    else c = CMD_READ;
    a  = mem_addr_t'(($urandom % 16) * 61);  // sixteen addresses over all fields.
    hi = force_hi || ($urandom % 4 == 0);
    issue_cmd(test, c, a, hi, data_t'($urandom));
  endtask

  always @(negedge clk) begin : read_monitor
    data_t     exp_d;
    mem_addr_t exp_a;
    string     exp_n;
    if (!reset && app_rd_data_valid) begin
      if (exp_data_q.size() == 0) begin
        stop_on_error("read data valid pulsed with no outstanding read");
      end else begin
        exp_d = exp_data_q.pop_front();
        exp_a = exp_addr_q.pop_front();
        exp_n = exp_name_q.pop_front();
        compare_data(exp_n, exp_a, exp_d, app_rd_data);
      end
    end
  end

  always @(negedge clk) begin : accept_monitor
    if (!reset && dut0.use_addr) begin
      use_count++;
      if (use_count > issued_count)
        stop_on_error("command stage passed on more commands than were accepted");
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d reads outstanding, %0d of %0d commands queued",
               cycle_count, exp_data_q.size(), use_count, issued_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin : stimulus
    int gap;
    clk          = 1'b0;
    reset        = 1'b1;
    app_addr     = '0;
    app_cmd      = CMD_WRITE;
    app_hi_pri   = 1'b0;
    app_en       = 1'b0;
    app_wdf_wren = 1'b0;
    app_wdf_data = '0;
    issued_count = 0;
    use_count    = 0;
    cycle_count  = 0;
    void'($urandom(SEED));
    for (int i = 0; i < 2**ADDR_WIDTH; i++) model[i] = '0;

    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      compare_bit("reset_rdy", 1'b0, app_rdy);
      compare_bit("reset_rd_valid", 1'b0, app_rd_data_valid);
    end
    reset = 1'b0;
    while (!app_rdy) begin
      compare_bit("post_reset_rd_valid", 1'b0, app_rd_data_valid);
      wait_cycles(1);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_cmd("random_mix", 1'b0);
      gap = int'($urandom % 4);
      if (gap != 0) wait_cycles(gap);
    end

    // back to back, so the queue and buffers push back.
    for (int i = 0; i < NUM_BURST; i++) random_cmd("backpressure_burst", 1'b0);

    for (int i = 0; i < NUM_HI; i++) begin
      random_cmd("refresh_hi_pri", 1'b1);
      gap = int'($urandom % 3);
      if (gap != 0) wait_cycles(gap);
    end

    while (exp_data_q.size() != 0 || use_count != issued_count) wait_cycles(1);
    wait_cycles(20);  // no stray valid pulse after the drain.

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* src.f */
rtl/mem_ui_pkg.sv
rtl/ui_cmd.sv
rtl/rd_data_buf.sv
rtl/wr_data_buf.sv
rtl/cmd_exec.sv
rtl/refresh_ctrl.sv
rtl/mem_arbiter.sv
rtl/mem_ui_top.sv
testbench/tb_mem_ui.sv

/* run.sh */
#!/usr/bin/env bash
# build the memory UI testbench with Verilator, run it and look for the pass line.
set -u
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f src.f --top-module tb_mem_ui
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output="$(./obj_dir/Vtb_mem_ui 2>&1)"
sim_status=$?
printf '%s\n' "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_output" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
